//--- dv/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
	import lsu_pkg::*;

	typedef struct packed {
		logic        valid;
		ls_op_e      op;
		mem_size_e   size;
		logic        uns;
		logic [31:0] base;
		logic [11:0] offset;
		logic [31:0] sdata;
		logic        rnd;
		logic        commit;
		logic        squash;
	} row_t;

	logic        clock;
	logic        reset;
	logic        issue_valid;
	ls_op_e      issue_op;
	mem_size_e   issue_size;
	logic        issue_unsigned;
	logic [31:0] issue_base;
	logic [11:0] issue_offset;
	logic [31:0] issue_store_data;
	logic [3:0]  issue_tag;
	logic        commit;
	logic        squash;
	logic        done;
	logic [3:0]  done_tag;
	logic [31:0] done_data;
	logic        sq_full;

	row_t        table_q[$];
	logic        table_ready = 1'b0;

	// reference model of committed bytes and pending stores with the oldest at the front
	logic [7:0]  ref_mem [0:1023];
	logic [7:0]  pend_addr[$];
	logic [3:0]  pend_mask[$];
	logic [31:0] pend_data[$];

	// operation issued at the last edge and the one reporting done now
	logic        issued_valid = 1'b0;
	logic        issued_store;
	logic [3:0]  issued_tag;
	logic [31:0] issued_data;
	logic [7:0]  issued_waddr;
	logic [3:0]  issued_mask;
	logic [31:0] issued_wdata;
	logic        report_valid = 1'b0;
	logic [3:0]  report_tag;
	logic [31:0] report_data;

	lsu_top i_lsu_top (
		.clock            (clock),
		.reset            (reset),
		.issue_valid      (issue_valid),
		.issue_op         (issue_op),
		.issue_size       (issue_size),
		.issue_unsigned   (issue_unsigned),
		.issue_base       (issue_base),
		.issue_offset     (issue_offset),
		.issue_store_data (issue_store_data),
		.issue_tag        (issue_tag),
		.commit           (commit),
		.squash           (squash),
		.done             (done),
		.done_tag         (done_tag),
		.done_data        (done_data),
		.sq_full          (sq_full)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input logic valid, input ls_op_e op, input mem_size_e size,
			input logic uns, input logic [31:0] base, input logic [11:0] offset,
			input logic [31:0] sdata, input logic rnd, input logic commit_en,
			input logic squash_en);
		row_t r;
		r.valid = valid;
		r.op = op;
		r.size = size;
		r.uns = uns;
		r.base = base;
		r.offset = offset;
		r.sdata = sdata;
		r.rnd = rnd;
		r.commit = commit_en;
		r.squash = squash_en;
		table_q.push_back(r);
	endtask

	task automatic add_load(input mem_size_e size, input logic uns, input logic [31:0] base,
			input logic [11:0] offset);
		add_row(1'b1, LS_LOAD, size, uns, base, offset, 32'h0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic add_store(input mem_size_e size, input logic [31:0] base,
			input logic [11:0] offset, input logic [31:0] sdata, input logic rnd);
		add_row(1'b1, LS_STORE, size, 1'b0, base, offset, sdata, rnd, 1'b0, 1'b0);
	endtask

	task automatic add_idle(input logic commit_en, input logic squash_en);
		add_row(1'b0, LS_LOAD, BYTE, 1'b0, 32'h0, 12'h0, 32'h0, 1'b0, commit_en, squash_en);
	endtask

	// committed word with pending bytes laid over it in age order
	function automatic logic [31:0] merged_word(input logic [7:0] waddr);
		logic [31:0] word;
		for (int b = 0; b < 4; b++) begin
			word[b*8 +: 8] = ref_mem[int'(waddr) * 4 + b];
			for (int k = 0; k < pend_addr.size(); k++) begin
				if (pend_addr[k] == waddr && pend_mask[k][b]) begin
					word[b*8 +: 8] = pend_data[k][b*8 +: 8];
				end
			end
		end
		return word;
	endfunction

	function automatic logic [31:0] expected_load(input logic [7:0] waddr, input int lane,
			input mem_size_e size, input logic uns);
		logic [31:0] shifted;
		shifted = merged_word(waddr) >> (lane * 8);
		case (size)
			BYTE: return uns ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
			HALF: return uns ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
			default: return shifted;
		endcase
	endfunction

	// what the coming rising edge does to the model
	task automatic update_model(input row_t r, input logic [31:0] data, input logic [3:0] tag);
		logic [31:0] addr;
		int lane;
		// the oldest store is written even when the same edge squashes
		if (r.commit && pend_addr.size() > 0) begin
			for (int b = 0; b < 4; b++) begin
				if (pend_mask[0][b]) begin
					ref_mem[int'(pend_addr[0]) * 4 + b] = pend_data[0][b*8 +: 8];
				end
			end
			void'(pend_addr.pop_front());
			void'(pend_mask.pop_front());
			void'(pend_data.pop_front());
		end
		if (r.squash) begin
			pend_addr.delete();
			pend_mask.delete();
			pend_data.delete();
			issued_valid = 1'b0;
			report_valid = 1'b0;
		end else begin
			if (issued_valid && issued_store) begin
				pend_addr.push_back(issued_waddr);
				pend_mask.push_back(issued_mask);
				pend_data.push_back(issued_wdata);
			end
			report_valid = issued_valid;
			report_tag = issued_tag;
			report_data = issued_data;
			issued_valid = r.valid;
			if (r.valid) begin
				addr = r.base + {{20{r.offset[11]}}, r.offset};
				case (r.size)
					BYTE: begin
						lane = int'(addr[1:0]);
						issued_mask = 4'b0001 << lane;
					end
					HALF: begin
						lane = addr[1] ? 2 : 0;
						issued_mask = 4'b0011 << lane;
					end
					default: begin
						lane = 0;
						issued_mask = 4'b1111;
					end
				endcase
				issued_store = (r.op == LS_STORE);
				issued_tag = tag;
				issued_waddr = addr[9:2];
				issued_wdata = data << (lane * 8);
				issued_data = issued_store ? 32'h0 :
					expected_load(addr[9:2], lane, r.size, r.uns);
			end
		end
	endtask

	task automatic drive_row(input row_t r, input int idx);
		logic [31:0] data;
		data = r.rnd ? $urandom() : r.sdata;
		issue_valid = r.valid;
		issue_op = r.op;
		issue_size = r.size;
		issue_unsigned = r.uns;
		issue_base = r.base;
		issue_offset = r.offset;
		issue_store_data = data;
		issue_tag = 4'(idx);
		commit = r.commit;
		squash = r.squash;
		update_model(r, data, 4'(idx));
	endtask

	task automatic check_outputs();
		check_value("done", 32'(done), 32'(report_valid));
		if (report_valid) begin
			check_value("done_tag", 32'(done_tag), 32'(report_tag));
			check_value("done_data", done_data, report_data);
		end
		check_value("sq_full", 32'(sq_full), 32'(pend_addr.size() == SQ_DEPTH));
	endtask

	initial begin
		wait (table_ready);
		#((table_q.size() + 20) * 10);
		$display("timeout: the run did not finish in the expected time");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(32'h3ff845b4));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = LS_LOAD;
		issue_size = BYTE;
		issue_unsigned = 1'b0;
		issue_base = 32'h0;
		issue_offset = 12'h0;
		issue_store_data = 32'h0;
		issue_tag = 4'h0;
		commit = 1'b0;
		squash = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			ref_mem[i] = 8'h00;
		end

		// untouched memory after reset
		add_idle(1'b0, 1'b0);
		add_load(WORD, 1'b0, 32'h200, 12'h0);
		add_load(BYTE, 1'b1, 32'h203, 12'h0);
		add_load(HALF, 1'b0, 32'h3fe, 12'h0);
		// committed word then loads at every lane
		add_store(WORD, 32'h100, 12'h0, 32'h80f17f02, 1'b0);
		add_idle(1'b0, 1'b0);
		add_idle(1'b1, 1'b0);
		for (int lane = 0; lane < 4; lane++) begin
			add_load(BYTE, 1'b0, 32'h100, 12'(lane));
			add_load(BYTE, 1'b1, 32'h100, 12'(lane));
		end
		for (int lane = 0; lane < 4; lane += 2) begin
			add_load(HALF, 1'b0, 32'h100, 12'(lane));
			add_load(HALF, 1'b1, 32'h100, 12'(lane));
		end
		add_load(WORD, 1'b0, 32'h104, 12'hffc);
		// overlapping uncommitted stores where the youngest byte wins
		add_store(WORD, 32'h140, 12'h0, 32'h0, 1'b1);
		add_idle(1'b0, 1'b0);
		add_idle(1'b1, 1'b0);
		add_store(BYTE, 32'h140, 12'h1, 32'h000000aa, 1'b0);
		add_store(HALF, 32'h140, 12'h2, 32'h000055cc, 1'b0);
		add_store(BYTE, 32'h140, 12'h2, 32'hffffff11, 1'b0);
		add_load(WORD, 1'b0, 32'h140, 12'h0);
		add_load(HALF, 1'b0, 32'h140, 12'h2);
		add_load(BYTE, 1'b1, 32'h13c, 12'h5);
		add_idle(1'b1, 1'b0);
		add_idle(1'b1, 1'b0);
		add_idle(1'b1, 1'b0);
		add_load(WORD, 1'b0, 32'h140, 12'h0);
		// back to back issues every cycle
		add_store(WORD, 32'h180, 12'h0, 32'h0, 1'b1);
		add_load(WORD, 1'b0, 32'h180, 12'h0);
		add_store(HALF, 32'h180, 12'h2, 32'h0, 1'b1);
		add_load(HALF, 1'b0, 32'h180, 12'h2);
		add_load(BYTE, 1'b0, 32'h180, 12'h3);
		add_idle(1'b1, 1'b0);
		add_idle(1'b1, 1'b0);
		add_load(WORD, 1'b1, 32'h180, 12'h0);
		// fill the queue and drain it
		for (int i = 0; i < 4; i++) begin
			add_store(WORD, 32'h1c0 + 32'(i * 4), 12'h0, 32'h0, 1'b1);
		end
		add_idle(1'b0, 1'b0);
		add_load(WORD, 1'b0, 32'h1c4, 12'h0);
		add_idle(1'b1, 1'b0);
		add_load(WORD, 1'b0, 32'h1c0, 12'h0);
		add_idle(1'b1, 1'b0);
		add_idle(1'b1, 1'b0);
		add_idle(1'b1, 1'b0);
		add_load(WORD, 1'b0, 32'h1cc, 12'h0);
		add_load(BYTE, 1'b0, 32'h1c8, 12'h1);
		// squash with a load in flight and two stores pending
		add_store(WORD, 32'h100, 12'h0, 32'hdeadbeef, 1'b0);
		add_store(HALF, 32'h104, 12'h0, 32'h0000beef, 1'b0);
		add_idle(1'b0, 1'b0);
		add_load(WORD, 1'b0, 32'h100, 12'h0);
		add_idle(1'b0, 1'b1);
		add_load(WORD, 1'b0, 32'h100, 12'h0);
		add_load(WORD, 1'b0, 32'h104, 12'h0);
		add_idle(1'b1, 1'b0);
		add_load(HALF, 1'b1, 32'h104, 12'h0);
		add_idle(1'b0, 1'b0);
		add_idle(1'b0, 1'b0);
		table_ready = 1'b1;

		repeat (4) @(negedge clock);
		reset = 1'b0;

		for (int i = 0; i < table_q.size(); i++) begin
			@(negedge clock);
			check_outputs();
			drive_row(table_q[i], i);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                              clock,
	input  logic [lsu_pkg::MEM_ADDR_LEN-1:0]  raddr,
	input  logic                              we,
	input  logic [lsu_pkg::MEM_ADDR_LEN-1:0]  waddr,
	input  logic [lsu_pkg::BYTE_LANES-1:0]    wmask,
	input  logic [lsu_pkg::XLEN-1:0]          wdata,
	output logic [lsu_pkg::XLEN-1:0]          rdata
);
	import lsu_pkg::*;

	logic [XLEN-1:0] mem [MEM_WORDS];

	// start from an all-zero image
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// byte lanes written independently
	always_ff @(posedge clock) begin
		if (we) begin
			for (int b = 0; b < BYTE_LANES; b++) begin
				if (wmask[b]) begin
					mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// read returns the old word on a same-address write
	always_ff @(posedge clock) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- hw/ls_fu.sv
`timescale 1ns/1ps
`default_nettype none

module ls_fu (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              squash,
	input  logic                              issue_valid,
	input  lsu_pkg::ls_op_e                   issue_op,
	input  lsu_pkg::mem_size_e                issue_size,
	input  logic                              issue_unsigned,
	input  logic [lsu_pkg::XLEN-1:0]          issue_base,
	input  logic [lsu_pkg::IMM_LEN-1:0]       issue_offset,
	input  logic [lsu_pkg::XLEN-1:0]          issue_store_data,
	input  logic [lsu_pkg::TAG_LEN-1:0]       issue_tag,
	lsu_req_if.fu                             req,
	output logic                              done,
	output logic [lsu_pkg::TAG_LEN-1:0]       done_tag,
	output logic [lsu_pkg::XLEN-1:0]          done_data
);
	import lsu_pkg::*;

	// issue register
	logic                  s1_valid;
	ls_op_e                s1_op;
	mem_size_e             s1_size;
	logic                  s1_unsigned;
	logic [XLEN-1:0]       s1_base;
	logic [IMM_LEN-1:0]    s1_offset;
	logic [XLEN-1:0]       s1_store_data;
	logic [TAG_LEN-1:0]    s1_tag;
	logic [XLEN-1:0]       s1_addr;
	logic [LANE_LEN-1:0]   s1_lane;
	logic [BYTE_LANES-1:0] s1_mask;

	// response stage
	logic                  s2_valid;
	ls_op_e                s2_op;
	mem_size_e             s2_size;
	logic                  s2_unsigned;
	logic [LANE_LEN-1:0]   s2_lane;
	logic [TAG_LEN-1:0]    s2_tag;
	logic [XLEN-1:0]       load_word;
	logic [XLEN-1:0]       load_ext;

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= issue_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			s1_op         <= issue_op;
			s1_size       <= issue_size;
			s1_unsigned   <= issue_unsigned;
			s1_base       <= issue_base;
			s1_offset     <= issue_offset;
			s1_store_data <= issue_store_data;
			s1_tag        <= issue_tag;
		end
		if (s1_valid) begin
			s2_op       <= s1_op;
			s2_size     <= s1_size;
			s2_unsigned <= s1_unsigned;
			s2_lane     <= s1_lane;
			s2_tag      <= s1_tag;
		end
	end

	// address generation, offset is sign extended
	assign s1_addr = s1_base + {{(XLEN-IMM_LEN){s1_offset[IMM_LEN-1]}}, s1_offset};

	// low address bits below the access size are dropped
	always_comb begin
		case (s1_size)
			BYTE: begin
				s1_lane = s1_addr[LANE_LEN-1:0];
				s1_mask = BYTE_LANES'(1) << s1_lane;
			end
			HALF: begin
				s1_lane = {s1_addr[LANE_LEN-1], 1'b0};
				s1_mask = BYTE_LANES'(3) << s1_lane;
			end
			default: begin
				s1_lane = '0;
				s1_mask = '1;
			end
		endcase
	end

	assign req.req_valid     = s1_valid;
	assign req.req_store     = (s1_op == LS_STORE);
	assign req.req_word_addr = s1_addr[LANE_LEN +: MEM_ADDR_LEN];
	assign req.req_byte_mask = s1_mask;
	assign req.req_wdata     = s1_store_data << {s1_lane, 3'b000};

	// bring the addressed bytes down to lane zero, then extend
	always_comb begin
		load_word = req.rsp_data >> {s2_lane, 3'b000};
		case (s2_size)
			BYTE:    load_ext = {{(XLEN-8){load_word[7] & ~s2_unsigned}}, load_word[7:0]};
			HALF:    load_ext = {{(XLEN-16){load_word[15] & ~s2_unsigned}}, load_word[15:0]};
			default: load_ext = load_word;
		endcase
	end

	assign done      = s2_valid;
	assign done_tag  = s2_tag;
	// stores report zero
	assign done_data = (s2_op == LS_STORE) ? '0 : load_ext;

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// datapath widths
	localparam int XLEN = 32;
	localparam int BYTE_LANES = XLEN / 8;
	localparam int LANE_LEN = $clog2(BYTE_LANES);

	// offset field of a load/store instruction
	localparam int IMM_LEN = 12;

	// tag carried from issue to done
	localparam int TAG_LEN = 4;

	// store queue geometry
	localparam int SQ_DEPTH = 4;
	localparam int SQ_IDX_LEN = 2;

	// data memory, addressed by word
	localparam int MEM_WORDS = 256;
	localparam int MEM_ADDR_LEN = $clog2(MEM_WORDS);

	// access size, same encoding as funct3[1:0]
	typedef enum logic [1:0] {
		BYTE = 2'h0,
		HALF = 2'h1,
		WORD = 2'h2
	} mem_size_e;

	// kind of memory operation
	typedef enum logic {
		LS_LOAD  = 1'b0,
		LS_STORE = 1'b1
	} ls_op_e;

endpackage

`default_nettype wire

//--- hw/lsu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lsu_req_if;
	import lsu_pkg::*;

	// request, one strobe per operation
	logic                    req_valid;
	logic                    req_store;
	logic [MEM_ADDR_LEN-1:0] req_word_addr;
	logic [BYTE_LANES-1:0]   req_byte_mask;
	logic [XLEN-1:0]         req_wdata;

	// response, rsp_data is the merged word one cycle after a load request
	logic [XLEN-1:0]         rsp_data;
	logic                    sq_full;

	modport fu (
		output req_valid, req_store, req_word_addr, req_byte_mask, req_wdata,
		input  rsp_data
	);

	modport lsq (
		input  req_valid, req_store, req_word_addr, req_byte_mask, req_wdata,
		output rsp_data, sq_full
	);

endinterface

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          issue_valid,
	input  lsu_pkg::ls_op_e               issue_op,
	input  lsu_pkg::mem_size_e            issue_size,
	input  logic                          issue_unsigned,
	input  logic [lsu_pkg::XLEN-1:0]      issue_base,
	input  logic [lsu_pkg::IMM_LEN-1:0]   issue_offset,
	input  logic [lsu_pkg::XLEN-1:0]      issue_store_data,
	input  logic [lsu_pkg::TAG_LEN-1:0]   issue_tag,
	input  logic                          commit,
	input  logic                          squash,
	output logic                          done,
	output logic [lsu_pkg::TAG_LEN-1:0]   done_tag,
	output logic [lsu_pkg::XLEN-1:0]      done_data,
	output logic                          sq_full
);
	import lsu_pkg::*;

	// store queue to memory
	logic [MEM_ADDR_LEN-1:0] mem_raddr;
	logic                    mem_we;
	logic [MEM_ADDR_LEN-1:0] mem_waddr;
	logic [BYTE_LANES-1:0]   mem_wmask;
	logic [XLEN-1:0]         mem_wdata;
	logic [XLEN-1:0]         mem_rdata;

	lsu_req_if req_bus ();

	ls_fu i_ls_fu (
		.clock            (clock),
		.reset            (reset),
		.squash           (squash),
		.issue_valid      (issue_valid),
		.issue_op         (issue_op),
		.issue_size       (issue_size),
		.issue_unsigned   (issue_unsigned),
		.issue_base       (issue_base),
		.issue_offset     (issue_offset),
		.issue_store_data (issue_store_data),
		.issue_tag        (issue_tag),
		.req              (req_bus.fu),
		.done             (done),
		.done_tag         (done_tag),
		.done_data        (done_data)
	);

	store_queue i_store_queue (
		.clock     (clock),
		.reset     (reset),
		.squash    (squash),
		.commit    (commit),
		.req       (req_bus.lsq),
		.mem_rdata (mem_rdata),
		.mem_raddr (mem_raddr),
		.mem_we    (mem_we),
		.mem_waddr (mem_waddr),
		.mem_wmask (mem_wmask),
		.mem_wdata (mem_wdata)
	);

	data_mem i_data_mem (
		.clock (clock),
		.raddr (mem_raddr),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wmask (mem_wmask),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	assign sq_full = req_bus.sq_full;

endmodule

`default_nettype wire

//--- hw/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                squash,
	input  logic                                commit,
	lsu_req_if.lsq                              req,
	input  logic [lsu_pkg::XLEN-1:0]            mem_rdata,
	output logic [lsu_pkg::MEM_ADDR_LEN-1:0]    mem_raddr,
	output logic                                mem_we,
	output logic [lsu_pkg::MEM_ADDR_LEN-1:0]    mem_waddr,
	output logic [lsu_pkg::BYTE_LANES-1:0]      mem_wmask,
	output logic [lsu_pkg::XLEN-1:0]            mem_wdata
);
	import lsu_pkg::*;

	// entry storage
	logic [MEM_ADDR_LEN-1:0] entry_addr [SQ_DEPTH];
	logic [BYTE_LANES-1:0]   entry_mask [SQ_DEPTH];
	logic [XLEN-1:0]         entry_data [SQ_DEPTH];

	logic [SQ_IDX_LEN-1:0]   head;
	logic [SQ_IDX_LEN-1:0]   tail;
	logic [SQ_IDX_LEN:0]     count;
	logic                    full;
	logic                    push;
	logic                    pop;

	// load forwarding
	logic [BYTE_LANES-1:0]   fwd_mask;
	logic [XLEN-1:0]         fwd_data;
	logic [BYTE_LANES-1:0]   fwd_mask_q;
	logic [XLEN-1:0]         fwd_data_q;
	logic [XLEN-1:0]         merged_data;

	assign full = (count == (SQ_IDX_LEN+1)'(SQ_DEPTH));
	assign push = req.req_valid && req.req_store && !full;
	assign pop  = commit && (count != '0);

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= tail + 1'b1;
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			count <= count + (SQ_IDX_LEN+1)'(push) - (SQ_IDX_LEN+1)'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			entry_addr[tail] <= req.req_word_addr;
			entry_mask[tail] <= req.req_byte_mask;
			entry_data[tail] <= req.req_wdata;
		end
	end

	// oldest first, so the youngest match is the last to write each byte
	always_comb begin
		logic [SQ_IDX_LEN-1:0] idx;
		fwd_mask = '0;
		fwd_data = '0;
		for (int k = 0; k < SQ_DEPTH; k++) begin
			idx = head + SQ_IDX_LEN'(k);
			if ((k < int'(count)) && (entry_addr[idx] == req.req_word_addr)) begin
				for (int b = 0; b < BYTE_LANES; b++) begin
					if (entry_mask[idx][b]) begin
						fwd_mask[b]          = 1'b1;
						fwd_data[b*8 +: 8]   = entry_data[idx][b*8 +: 8];
					end
				end
			end
		end
	end

	// captured alongside the memory read
	always_ff @(posedge clock) begin
		if (reset) begin
			fwd_mask_q <= '0;
		end else if (req.req_valid && !req.req_store) begin
			fwd_mask_q <= fwd_mask;
		end
	end

	always_ff @(posedge clock) begin
		if (req.req_valid && !req.req_store) begin
			fwd_data_q <= fwd_data;
		end
	end

	always_comb begin
		for (int b = 0; b < BYTE_LANES; b++) begin
			merged_data[b*8 +: 8] = fwd_mask_q[b] ? fwd_data_q[b*8 +: 8] : mem_rdata[b*8 +: 8];
		end
	end

	assign req.rsp_data = merged_data;
	assign req.sq_full  = full;

	assign mem_raddr = req.req_word_addr;

	// commit drains the head entry
	assign mem_we    = pop;
	assign mem_waddr = entry_addr[head];
	assign mem_wmask = entry_mask[head];
	assign mem_wdata = entry_data[head];

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f sources.f --top-module lsu_tb \
	-Mdir "$BUILD_DIR" -o lsu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/lsu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sources.f
hw/lsu_pkg.sv
hw/lsu_req_if.sv
hw/ls_fu.sv
hw/store_queue.sv
hw/data_mem.sv
hw/lsu_top.sv
dv/lsu_tb.sv
